// File: compile.f
logic/cpuPkg.sv
logic/busRegister.sv
logic/registerFile.sv
logic/alu.sv
logic/dataPath.sv
logic/stepCounter.sv
logic/controlUnit.sv
logic/cpuCore.sv
tb/cpuCoreTb.sv

// File: logic/alu.sv
`timescale 1ns/1ps

module alu
	import cpuPkg::*;
(
	input wordT a,
	input wordT b,
	input logic [aluOpWidth-1:0] op,
	output productT result
);
	logic [4:0] shamt;
	logic [2*wordWidth-1:0] doubled;
	logic signed [2*wordWidth-1:0] product;
	wordT word;

	assign shamt = b[4:0];
	assign doubled = {a, a}; // rotates come out of the doubled word
	assign product = $signed(a) * $signed(b);

	always_comb begin
		word = '0;
		case (op)
			aluAdd: word = a + b;
			aluSub: word = a - b;
			aluAnd: word = a & b;
			aluOr: word = a | b;
			aluShr: word = a >> shamt;
			aluShra: word = $signed(a) >>> shamt; // sign fill
			aluShl: word = a << shamt;
			aluRor: word = wordT'(doubled >> shamt);
			aluRol: word = wordT'((doubled << shamt) >> wordWidth);
			aluNeg: word = -b;
			aluNot: word = ~b;
			default: word = '0;
		endcase
	end

	assign result = (op == aluMul) ? productT'(product) : productT'(word);
endmodule

// File: logic/busRegister.sv
`timescale 1ns/1ps

module busRegister
	import cpuPkg::*;
#(
	parameter type payloadT = wordT
) (
	input logic Clock,
	input logic rst,
	input logic enable,
	input payloadT d,
	output payloadT q
);
	always_ff @(posedge Clock) begin
		if (rst) begin
			q <= '0;
		end else if (enable) begin
			q <= d;
		end
	end
endmodule

// File: logic/controlUnit.sv
`timescale 1ns/1ps

module controlUnit
	import cpuPkg::*;
(
	input logic Clock,
	input logic rst,
	input wordT ir,
	input logic [stepWidth-1:0] step,
	output logic hold,
	output logic stepClear,
	output logic [busSrcWidth-1:0] busSrc,
	output logic [regIdxWidth-1:0] busReg,
	output logic regWrite,
	output logic [regIdxWidth-1:0] regWriteIdx,
	output logic pcIn,
	output logic irIn,
	output logic yIn,
	output logic zIn,
	output logic marIn,
	output logic mdrIn,
	output logic hiIn,
	output logic loIn,
	output logic outIn,
	output logic incPc,
	output logic memRead,
	output logic [aluOpWidth-1:0] aluOp,
	output logic outValid,
	output logic halted
);
	logic [opcodeWidth-1:0] opcode;
	logic [regIdxWidth-1:0] ra, rb, rc;
	logic haltState, haltNow;

	assign opcode = ir[opcodeMsb:opcodeLsb];
	assign ra = ir[raMsb:raLsb];
	assign rb = ir[rbMsb:rbLsb];
	assign rc = ir[rcMsb:rcLsb];
	assign haltNow = (step == stepWidth'(3)) && (opcode >= opHalt); // unknown opcodes halt too
	assign halted = haltState | haltNow;
	assign hold = halted;
	assign regWriteIdx = ra;

	always_comb begin
		case (opcode)
			opSub: aluOp = aluSub;
			opAnd: aluOp = aluAnd;
			opOr: aluOp = aluOr;
			opShr: aluOp = aluShr;
			opShra: aluOp = aluShra;
			opShl: aluOp = aluShl;
			opRor: aluOp = aluRor;
			opRol: aluOp = aluRol;
			opMul: aluOp = aluMul;
			opNeg: aluOp = aluNeg;
			opNot: aluOp = aluNot;
			default: aluOp = aluAdd; // add, addi
		endcase
	end

	always_comb begin
		{stepClear, regWrite, pcIn, irIn, yIn, zIn, marIn, mdrIn} = '0;
		{hiIn, loIn, outIn, incPc, memRead} = '0;
		busSrc = srcNone;
		busReg = rb;
		case (step)
			0: begin
				busSrc = srcPc;
				{marIn, incPc, zIn} = '1;
			end
			1: begin
				busSrc = srcZlo;
				{pcIn, memRead, mdrIn} = '1; // memory word into MDR
			end
			2: begin
				busSrc = srcMdr;
				irIn = 1'b1;
			end
			3: case (opcode)
				opAdd, opSub, opAnd, opOr, opShr, opShra, opShl, opRor, opRol,
				opAddi, opMul: begin
					busSrc = srcReg;
					yIn = 1'b1;
				end
				opNeg, opNot: begin
					busSrc = srcReg;
					zIn = 1'b1;
				end
				opMfhi, opMflo: begin
					busSrc = (opcode == opMfhi) ? srcHi : srcLo;
					{regWrite, stepClear} = '1;
				end
				opOut: begin
					busSrc = srcReg;
					busReg = ra;
					{outIn, stepClear} = '1;
				end
				default: ; // halt holds the step counter
			endcase
			4: case (opcode)
				opNeg, opNot: begin
					busSrc = srcZlo;
					{regWrite, stepClear} = '1;
				end
				default: begin
					busSrc = (opcode == opAddi) ? srcImm : srcReg;
					busReg = rc;
					zIn = 1'b1;
				end
			endcase
			5: begin
				busSrc = srcZlo;
				if (opcode == opMul) begin
					loIn = 1'b1;
				end else begin
					{regWrite, stepClear} = '1;
				end
			end
			6: begin
				busSrc = srcZhi; // upper product half
				{hiIn, stepClear} = '1;
			end
			default: stepClear = 1'b1;
		endcase
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			outValid <= 1'b0;
			haltState <= 1'b0;
		end else begin
			outValid <= outIn; // one cycle after the port loads
			if (haltNow) begin
				haltState <= 1'b1;
			end
		end
	end
endmodule

// File: logic/cpuCore.sv
`timescale 1ns/1ps

module cpuCore
	import cpuPkg::*;
(
	input logic Clock,
	input logic rst,
	input wordT memData,
	output wordT memAddr,
	output logic memRead,
	output wordT outPort,
	output logic outValid,
	output logic halted
);
	wordT ir;
	logic [stepWidth-1:0] step;
	logic hold, stepClear;
	logic [busSrcWidth-1:0] busSrc;
	logic [regIdxWidth-1:0] busReg, regWriteIdx;
	logic regWrite, pcIn, irIn, yIn, zIn, marIn, mdrIn;
	logic hiIn, loIn, outIn, incPc;
	logic [aluOpWidth-1:0] aluOp;

	controlUnit controlUnit_i (
		.Clock(Clock),
		.rst(rst),
		.ir(ir),
		.step(step),
		.hold(hold),
		.stepClear(stepClear),
		.busSrc(busSrc),
		.busReg(busReg),
		.regWrite(regWrite),
		.regWriteIdx(regWriteIdx),
		.pcIn(pcIn),
		.irIn(irIn),
		.yIn(yIn),
		.zIn(zIn),
		.marIn(marIn),
		.mdrIn(mdrIn),
		.hiIn(hiIn),
		.loIn(loIn),
		.outIn(outIn),
		.incPc(incPc),
		.memRead(memRead),
		.aluOp(aluOp),
		.outValid(outValid),
		.halted(halted)
	);

	stepCounter stepCounter_i (
		.Clock(Clock),
		.rst(rst),
		.stepClear(stepClear),
		.hold(hold),
		.step(step)
	);

	dataPath dataPath_i (
		.Clock(Clock),
		.rst(rst),
		.busSrc(busSrc),
		.busReg(busReg),
		.regWrite(regWrite),
		.regWriteIdx(regWriteIdx),
		.pcIn(pcIn),
		.irIn(irIn),
		.yIn(yIn),
		.zIn(zIn),
		.marIn(marIn),
		.mdrIn(mdrIn),
		.hiIn(hiIn),
		.loIn(loIn),
		.outIn(outIn),
		.incPc(incPc),
		.memRead(memRead),
		.aluOp(aluOp),
		.memData(memData),
		.ir(ir),
		.memAddr(memAddr),
		.outPort(outPort)
	);
endmodule

// File: logic/cpuPkg.sv
package cpuPkg;
	localparam int wordWidth = 32;
	typedef logic [wordWidth-1:0] wordT;
	typedef logic [2*wordWidth-1:0] productT;

	localparam int regCount = 16;
	localparam int regIdxWidth = 4;
	localparam int opcodeWidth = 5;
	localparam int stepWidth = 3; // T0..T6

	// instruction fields
	localparam int opcodeMsb = 31;
	localparam int opcodeLsb = 27;
	localparam int raMsb = 26;
	localparam int raLsb = 23;
	localparam int rbMsb = 22;
	localparam int rbLsb = 19;
	localparam int rcMsb = 18;
	localparam int rcLsb = 15;
	localparam int immMsb = 18; // immediate is ir[18:0], sign extended

	localparam logic [opcodeWidth-1:0] opAdd = 5'd0;
	localparam logic [opcodeWidth-1:0] opSub = 5'd1;
	localparam logic [opcodeWidth-1:0] opAnd = 5'd2;
	localparam logic [opcodeWidth-1:0] opOr = 5'd3;
	localparam logic [opcodeWidth-1:0] opShr = 5'd4;
	localparam logic [opcodeWidth-1:0] opShra = 5'd5;
	localparam logic [opcodeWidth-1:0] opShl = 5'd6;
	localparam logic [opcodeWidth-1:0] opRor = 5'd7;
	localparam logic [opcodeWidth-1:0] opRol = 5'd8;
	localparam logic [opcodeWidth-1:0] opAddi = 5'd9;
	localparam logic [opcodeWidth-1:0] opMul = 5'd10;
	localparam logic [opcodeWidth-1:0] opNeg = 5'd11;
	localparam logic [opcodeWidth-1:0] opNot = 5'd12;
	localparam logic [opcodeWidth-1:0] opMfhi = 5'd13;
	localparam logic [opcodeWidth-1:0] opMflo = 5'd14;
	localparam logic [opcodeWidth-1:0] opOut = 5'd15;
	localparam logic [opcodeWidth-1:0] opHalt = 5'd16; // and everything above

	localparam int aluOpWidth = 4;
	localparam logic [aluOpWidth-1:0] aluAdd = 4'd0;
	localparam logic [aluOpWidth-1:0] aluSub = 4'd1;
	localparam logic [aluOpWidth-1:0] aluMul = 4'd2;
	localparam logic [aluOpWidth-1:0] aluAnd = 4'd3;
	localparam logic [aluOpWidth-1:0] aluOr = 4'd4;
	localparam logic [aluOpWidth-1:0] aluShr = 4'd5;
	localparam logic [aluOpWidth-1:0] aluShra = 4'd6;
	localparam logic [aluOpWidth-1:0] aluShl = 4'd7;
	localparam logic [aluOpWidth-1:0] aluRor = 4'd8;
	localparam logic [aluOpWidth-1:0] aluRol = 4'd9;
	localparam logic [aluOpWidth-1:0] aluNeg = 4'd10;
	localparam logic [aluOpWidth-1:0] aluNot = 4'd11;

	localparam int busSrcWidth = 4;
	localparam logic [busSrcWidth-1:0] srcNone = 4'd0;
	localparam logic [busSrcWidth-1:0] srcPc = 4'd1;
	localparam logic [busSrcWidth-1:0] srcReg = 4'd2;
	localparam logic [busSrcWidth-1:0] srcZlo = 4'd3;
	localparam logic [busSrcWidth-1:0] srcZhi = 4'd4;
	localparam logic [busSrcWidth-1:0] srcMdr = 4'd5;
	localparam logic [busSrcWidth-1:0] srcImm = 4'd6;
	localparam logic [busSrcWidth-1:0] srcHi = 4'd7;
	localparam logic [busSrcWidth-1:0] srcLo = 4'd8;
endpackage

// File: logic/dataPath.sv
`timescale 1ns/1ps

module dataPath
	import cpuPkg::*;
(
	input logic Clock,
	input logic rst,
	input logic [busSrcWidth-1:0] busSrc,
	input logic [regIdxWidth-1:0] busReg,
	input logic regWrite,
	input logic [regIdxWidth-1:0] regWriteIdx,
	input logic pcIn,
	input logic irIn,
	input logic yIn,
	input logic zIn,
	input logic marIn,
	input logic mdrIn,
	input logic hiIn,
	input logic loIn,
	input logic outIn,
	input logic incPc,
	input logic memRead,
	input logic [aluOpWidth-1:0] aluOp,
	input wordT memData,
	output wordT ir,
	output wordT memAddr,
	output wordT outPort
);
	wordT bus;
	wordT pc, y, mdr, hi, lo, regRead, imm, aluA, mdrD;
	productT z, aluResult;
	logic [aluOpWidth-1:0] aluSel;

	assign imm = {{(wordWidth-immMsb-1){ir[immMsb]}}, ir[immMsb:0]};
	assign aluA = incPc ? wordT'(1) : y; // pc + 1 during fetch
	assign aluSel = incPc ? aluAdd : aluOp;
	assign mdrD = memRead ? memData : bus;

	always_comb begin
		case (busSrc)
			srcPc: bus = pc;
			srcReg: bus = regRead;
			srcZlo: bus = z[wordWidth-1:0];
			srcZhi: bus = z[2*wordWidth-1:wordWidth];
			srcMdr: bus = mdr;
			srcImm: bus = imm;
			srcHi: bus = hi;
			srcLo: bus = lo;
			default: bus = '0; // idle bus
		endcase
	end

	busRegister pcReg (.Clock(Clock), .rst(rst), .enable(pcIn), .d(bus), .q(pc));
	busRegister irReg (.Clock(Clock), .rst(rst), .enable(irIn), .d(bus), .q(ir));
	busRegister yReg (.Clock(Clock), .rst(rst), .enable(yIn), .d(bus), .q(y));
	busRegister marReg (.Clock(Clock), .rst(rst), .enable(marIn), .d(bus), .q(memAddr));
	busRegister mdrReg (.Clock(Clock), .rst(rst), .enable(mdrIn), .d(mdrD), .q(mdr));
	busRegister hiReg (.Clock(Clock), .rst(rst), .enable(hiIn), .d(bus), .q(hi));
	busRegister loReg (.Clock(Clock), .rst(rst), .enable(loIn), .d(bus), .q(lo));
	busRegister outReg (.Clock(Clock), .rst(rst), .enable(outIn), .d(bus), .q(outPort));

	busRegister #(.payloadT(productT)) zReg (
		.Clock(Clock),
		.rst(rst),
		.enable(zIn),
		.d(aluResult),
		.q(z)
	);

	registerFile regFile (
		.Clock(Clock),
		.rst(rst),
		.writeEn(regWrite),
		.writeIdx(regWriteIdx),
		.writeData(bus),
		.readIdx(busReg),
		.readData(regRead)
	);

	alu alu_i (
		.a(aluA),
		.b(bus),
		.op(aluSel),
		.result(aluResult)
	);
endmodule

// File: logic/registerFile.sv
`timescale 1ns/1ps

module registerFile
	import cpuPkg::*;
(
	input logic Clock,
	input logic rst,
	input logic writeEn,
	input logic [regIdxWidth-1:0] writeIdx,
	input wordT writeData,
	input logic [regIdxWidth-1:0] readIdx,
	output wordT readData
);
	wordT regs [1:regCount-1]; // no storage behind R0

	always_ff @(posedge Clock) begin
		if (rst) begin
			for (int i = 1; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeIdx != '0) begin
			regs[writeIdx] <= writeData;
		end
	end

	assign readData = (readIdx == '0) ? '0 : regs[readIdx]; // R0 reads zero
endmodule

// File: logic/stepCounter.sv
`timescale 1ns/1ps

module stepCounter
	import cpuPkg::*;
(
	input logic Clock,
	input logic rst,
	input logic stepClear,
	input logic hold,
	output logic [stepWidth-1:0] step
);
	always_ff @(posedge Clock) begin
		if (rst) begin
			step <= '0;
		end else if (hold) begin
			step <= step; // frozen on halt
		end else if (stepClear) begin
			step <= '0;
		end else begin
			step <= step + 1'b1;
		end
	end
endmodule

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module cpuCoreTb \
	-Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
	exit 0
fi
exit 1

// File: tb/cpuCoreTb.sv
`timescale 1ns/1ps

module cpuCoreTb
	import cpuPkg::*;
();
	localparam int clkPeriod = 8;
	localparam int memDepth = 256;
	localparam int resetCycles = 8;
	localparam int haltWindow = 20;
	// instructions summed over all seven programs
	localparam int instrBudget = 7 + 3 * 27 + 2 * 14 + 9;
	localparam int runCount = 7;
	localparam int timeoutCycles =
		instrBudget * 7 + runCount * (resetCycles + haltWindow + 4) + 100;
	localparam logic [opcodeWidth-1:0] aluOpList [0:8] = '{
		opAdd, opSub, opAnd, opOr, opShr, opShra, opShl, opRor, opRol
	};

	logic Clock;
	logic rst;
	wordT memData = '0;
	wordT memAddr;
	wordT outPort;
	logic memRead;
	logic outValid;
	logic halted;

	integer seed = 32'h158f_2734;
	int errors = 0;
	int checks = 0;
	int progLen;
	wordT prog [0:memDepth-1];
	wordT model [0:regCount-1]; // expected register contents
	wordT hiModel;
	wordT loModel;
	wordT expected [$];

	cpuCore cpuCore_i (
		.Clock(Clock),
		.rst(rst),
		.memData(memData),
		.memAddr(memAddr),
		.memRead(memRead),
		.outPort(outPort),
		.outValid(outValid),
		.halted(halted)
	);

	initial begin
		Clock = 1'b0;
		forever #(clkPeriod / 2) Clock = ~Clock;
	end

	always @(negedge Clock) begin
		memData <= prog[memAddr[7:0]]; // word addressed
	end

	function automatic wordT extendImm(input logic [18:0] c);
		return {{13{c[18]}}, c};
	endfunction

	function automatic wordT encode(input logic [opcodeWidth-1:0] op, input int ra,
			input int rb, input logic [18:0] low);
		return {op, 4'(ra), 4'(rb), low};
	endfunction

	function automatic wordT aluModel(input logic [opcodeWidth-1:0] op, input wordT a,
			input wordT b);
		int n;
		n = int'(b[4:0]); // shift count
		case (op)
			opAdd: return a + b;
			opSub: return a - b;
			opAnd: return a & b;
			opOr: return a | b;
			opShr: return a >> n;
			opShra: return wordT'($signed(a) >>> n);
			opShl: return a << n;
			opRor: return (a >> n) | (a << (32 - n));
			opRol: return (a << n) | (a >> (32 - n));
			opNeg: return '0 - b;
			opNot: return ~b;
			default: return '0;
		endcase
	endfunction

	task automatic expectLevel(input string sigName, input logic got, input logic want,
			input string ctx);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERROR %s: got %h expected %h (%s)", sigName, got, want, ctx);
		end
	endtask

	task automatic newProgram();
		for (int i = 0; i < memDepth; i++) begin
			prog[i] = {opHalt, 27'(i)}; // spare words halt
		end
		for (int i = 0; i < regCount; i++) begin
			model[i] = '0;
		end
		hiModel = '0;
		loModel = '0;
		progLen = 0;
		expected.delete();
	endtask

	task automatic appendWord(input wordT w);
		prog[progLen] = w;
		progLen++;
	endtask

	task automatic writeModel(input int idx, input wordT v);
		if (idx != 0) begin
			model[idx] = v; // R0 stays zero
		end
	endtask

	task automatic threeReg(input logic [opcodeWidth-1:0] op, input int ra, input int rb,
			input int rc);
		appendWord(encode(op, ra, rb, {4'(rc), 15'd0}));
		writeModel(ra, aluModel(op, model[rb], model[rc]));
	endtask

	task automatic addImm(input int ra, input int rb, input logic [18:0] c);
		appendWord(encode(opAddi, ra, rb, c));
		writeModel(ra, model[rb] + extendImm(c));
	endtask

	task automatic multiply(input int rb, input int rc);
		logic signed [63:0] p;
		appendWord(encode(opMul, 0, rb, {4'(rc), 15'd0}));
		p = 64'($signed(model[rb])) * 64'($signed(model[rc]));
		hiModel = p[63:32];
		loModel = p[31:0];
	endtask

	task automatic unaryOp(input logic [opcodeWidth-1:0] op, input int ra, input int rb);
		appendWord(encode(op, ra, rb, '0));
		writeModel(ra, aluModel(op, '0, model[rb]));
	endtask

	task automatic moveFrom(input logic [opcodeWidth-1:0] op, input int ra);
		appendWord(encode(op, ra, 0, '0));
		writeModel(ra, (op == opMfhi) ? hiModel : loModel);
	endtask

	task automatic outputReg(input int ra);
		appendWord(encode(opOut, ra, 0, '0));
		expected.push_back(model[ra]);
	endtask

	task automatic haltProgram();
		appendWord(encode(opHalt, 0, 0, '0));
	endtask

	// upper half shifted up by r15 and the lower half added
	task automatic loadWord(input int ra, input wordT v);
		addImm(15, 0, 19'd16);
		addImm(ra, 0, {3'b000, v[31:16]});
		threeReg(opShl, ra, ra, 15);
		addImm(ra, ra, {3'b000, v[15:0]});
	endtask

	task automatic resetDut();
		@(negedge Clock);
		rst = 1'b1;
		repeat (resetCycles) @(negedge Clock);
		expectLevel("memRead", memRead, 1'b0, "reset");
		expectLevel("outValid", outValid, 1'b0, "reset");
		expectLevel("halted", halted, 1'b0, "reset");
		rst = 1'b0;
	endtask

	task automatic runProgram(input string name);
		int fetchAddr;
		logic lastValid;
		wordT want;
		fetchAddr = 0;
		lastValid = 1'b0;
		resetDut();
		while (!halted) begin
			@(negedge Clock);
			if (memRead) begin
				checks++;
				if (memAddr !== wordT'(fetchAddr)) begin
					errors++;
					$display("ERROR memAddr: got %h expected %h (%s)", memAddr,
						wordT'(fetchAddr), name);
				end
				fetchAddr++;
			end
			if (outValid) begin
				if (lastValid) begin
					errors++;
					$display("outValid stayed high for more than one cycle (%s)", name);
				end else if (expected.size() == 0) begin
					errors++;
					$display("outValid pulsed with no output expected (%s)", name);
				end else begin
					want = expected.pop_front();
					checks++;
					if (outPort !== want) begin
						errors++;
						$display("ERROR outPort: got %h expected %h (%s)", outPort, want, name);
					end
				end
			end
			lastValid = outValid;
		end
		if (expected.size() != 0) begin
			errors++;
			$display("%0d output values never appeared (%s)", expected.size(), name);
		end
		if (fetchAddr != progLen) begin
			errors++;
			$display("fetched %0d words but the program has %0d (%s)", fetchAddr, progLen, name);
		end
		repeat (haltWindow) begin
			@(negedge Clock);
			expectLevel("halted", halted, 1'b1, name);
			expectLevel("memRead", memRead, 1'b0, name);
			expectLevel("outValid", outValid, 1'b0, name);
		end
	endtask

	task automatic r0Behavior();
		logic [18:0] c;
		c = 19'($random(seed));
		c[18] = 1'b1; // negative, so sign extension shows
		newProgram();
		addImm(1, 0, c);
		outputReg(1);
		addImm(0, 1, 19'd5);
		outputReg(0);
		threeReg(opAdd, 2, 0, 1);
		outputReg(2);
		haltProgram();
		runProgram("addi and R0");
	endtask

	task automatic aluBehavior();
		wordT a;
		wordT b;
		for (int round = 0; round < 3; round++) begin
			a = $random(seed);
			b = $random(seed);
			if (round == 1) begin
				a[31] = 1'b1; // shra has to fill ones
			end
			newProgram();
			loadWord(1, a);
			loadWord(2, b);
			for (int k = 0; k < 9; k++) begin
				threeReg(aluOpList[k], 3, 1, 2);
				outputReg(3);
			end
			haltProgram();
			runProgram("three-register ALU");
		end
	endtask

	task automatic mulBehavior();
		wordT a;
		wordT b;
		for (int round = 0; round < 2; round++) begin
			a = $random(seed);
			b = $random(seed);
			a[31] = 1'b1;
			b[31] = (round == 1); // second round both negative
			newProgram();
			loadWord(1, a);
			loadWord(2, b);
			multiply(1, 2);
			moveFrom(opMflo, 3);
			outputReg(3);
			moveFrom(opMfhi, 4);
			outputReg(4);
			haltProgram();
			runProgram("mul");
		end
	endtask

	task automatic unaryBehavior();
		wordT a;
		a = $random(seed);
		newProgram();
		loadWord(1, a);
		unaryOp(opNeg, 3, 1);
		outputReg(3);
		unaryOp(opNot, 4, 1);
		outputReg(4);
		haltProgram();
		runProgram("neg and not");
	endtask

	initial begin
		rst = 1'b1;
		newProgram();
		r0Behavior();
		aluBehavior();
		mulBehavior();
		unaryBehavior();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		#(timeoutCycles * clkPeriod);
		$display("timeout: the programs did not finish within %0d cycles", timeoutCycles);
		$display("Simulation failed");
		$finish;
	end
endmodule
